//--- opl3_phase_gen.f
+incdir+design
design/opl3_phase_pkg.sv
design/opl3_reg_pkg.sv
design/opl3_op_regs.sv
design/nco_control.sv
design/nco.sv
design/opl3_phase_gen.sv
tests/tb_opl3_phase_gen.sv

//--- Makefile
# Verilator flow for the opl3 phase generator
#   make lint      lint the testbench and the RTL top level
#   make sim       build and run the testbench, pass only if the log shows the pass line
#   make clean     remove build output and the log

VERILATOR ?= verilator
TOP       ?= tb_opl3_phase_gen
RTL_TOP   ?= opl3_phase_gen
FILELIST  ?= opl3_phase_gen.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTS PASSED
JOBS      ?= 0
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := design/opl3_consts.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint lint_tb lint_rtl build sim clean

all: sim

lint: lint_rtl lint_tb

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

lint_tb:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

# the exit status comes from the search, not from the simulator
sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }
	@echo "simulation passed, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_opl3_phase_gen.sv
//====================
// opl3 phase generator testbench
// drives register writes and sample pulses into one operator
// and checks the phase output against a model accumulator
//====================
`timescale 1ns/1ns
`default_nettype none

`include "opl3_consts.svh"

module tb_opl3_phase_gen;
    import opl3_phase_pkg::*;
    import opl3_reg_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int T1_CYCLES  = 40;    // reset and unconfigured pulses
    localparam int T2_CYCLES  = 170;   // three writes and 64 pulses
    localparam int T3_CYCLES  = 1250;  // 16 codes, each with writes and 20 pulses
    localparam int T4_CYCLES  = 1300;  // three rounds of 200 pulses
    localparam int T5_CYCLES  = 260;   // key-on drops and restarts
    localparam int T6_CYCLES  = 820;   // 100 pulses with gaps up to 5 cycles
    localparam int RUN_CYCLES = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES +
                                T5_CYCLES + T6_CYCLES;

    logic                         clk;
    logic                         arst_n;
    logic                         wr;
    logic [`OPL3_ADDR_W-1:0]      addr;
    reg_wdata_u                   wdata;
    logic                         sample_en;
    phase_t                       phase;

    logic [`OPL3_PHASE_ACC_W-1:0] model_acc;  // expected accumulator contents
    logic [`OPL3_FNUM_W-1:0]      cfg_fnum;   // model copy of the operator registers
    logic [`OPL3_BLOCK_W-1:0]     cfg_block;
    logic [`OPL3_MULT_W-1:0]      cfg_mult;
    logic                         cfg_key;
    logic                         check_en;   // compare process runs only while set
    logic [`OPL3_FNUM_W-1:0]      rnd_fnum;
    logic [`OPL3_ADDR_W-1:0]      rnd_addr;
    int                           errors;
    int                           err_mark;
    int                           tests_passed;
    int                           tests_failed;
    int                           n;
    int                           k;

    opl3_phase_gen i_opl3_phase_gen (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .sample_en (sample_en),
        .phase     (phase)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // budget covers every test plus a margin of 200 cycles
    initial begin
        #(RUN_CYCLES * CLK_PERIOD + 200 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES + 200);
        $display("TESTS FAILED");
        $finish;
    end

    // expected increment, written from the register description of the chip
    function automatic logic [`OPL3_PHASE_ACC_W-1:0] ref_inc(
        input logic [`OPL3_FNUM_W-1:0]  fnum,
        input logic [`OPL3_BLOCK_W-1:0] block,
        input logic [`OPL3_MULT_W-1:0]  mult
    );
        logic [31:0] shifted;
        logic [31:0] factor;
        logic [31:0] scaled;
        shifted = 32'(fnum) << block;
        case (mult)
            4'hB:       factor = 32'd10;
            4'hC, 4'hD: factor = 32'd12;
            4'hE, 4'hF: factor = 32'd15;
            default:    factor = 32'(mult);
        endcase
        if (mult == 4'h0) begin
            scaled = shifted >> 1; // code 0 is a factor of one half
        end else begin
            scaled = shifted * factor;
        end
        return scaled[`OPL3_PHASE_ACC_W-1:0];
    endfunction

    function automatic logic is_mapped(input logic [`OPL3_ADDR_W-1:0] a);
        return (a == `OPL3_ADDR_OP) || (a == `OPL3_ADDR_FNUM_LO) || (a == `OPL3_ADDR_CTRL);
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors = errors + 1;
            $display("[FAIL] %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    // phase is stable at the falling edge, half a cycle after any update
    always @(negedge clk) begin
        if (check_en) begin
            check("phase", 32'(phase),
                  32'(model_acc[`OPL3_PHASE_ACC_W-1 -: `OPL3_PHASE_OUT_W]));
        end
    end

    task automatic write_reg(input logic [`OPL3_ADDR_W-1:0] a, input logic [7:0] d);
        @(posedge clk);
        wr    <= 1'b1;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        wr    <= 1'b0; // register file captures on this edge
    endtask

    task automatic settle();
        repeat (8) @(posedge clk); // increment pipeline needs four cycles after a write
    endtask

    // writes both F-number registers, key-on travels in the control byte
    task automatic set_freq(input logic [`OPL3_FNUM_W-1:0] fnum,
                            input logic [`OPL3_BLOCK_W-1:0] block, input logic key);
        check_en = 1'b0;
        write_reg(`OPL3_ADDR_FNUM_LO, fnum[7:0]);
        write_reg(`OPL3_ADDR_CTRL, {2'b00, key, block, fnum[`OPL3_FNUM_W-1:8]});
        settle();
        if (key && !cfg_key) begin
            model_acc = '0; // rising key-on restarts the phase
        end
        cfg_fnum  = fnum;
        cfg_block = block;
        cfg_key   = key;
        check_en  = 1'b1;
    endtask

    // the upper nibble carries am, vib, egt and ksr, filled at random
    task automatic set_mult(input logic [`OPL3_MULT_W-1:0] mult);
        check_en = 1'b0;
        write_reg(`OPL3_ADDR_OP, {4'($urandom), mult});
        settle();
        cfg_mult = mult;
        check_en = 1'b1;
    endtask

    task automatic restart_key();
        set_freq(cfg_fnum, cfg_block, 1'b0);
        set_freq(cfg_fnum, cfg_block, 1'b1);
    endtask

    task automatic pulse(input int gap);
        @(posedge clk);
        sample_en <= 1'b1;
        @(posedge clk);
        sample_en <= 1'b0;
        model_acc = model_acc + ref_inc(cfg_fnum, cfg_block, cfg_mult); // wraps at 2**20
        repeat (gap) @(posedge clk);
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == err_mark) begin
            tests_passed = tests_passed + 1;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: %0d mismatches", num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        arst_n    = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        wdata     = '0;
        sample_en = 1'b0;
        model_acc = '0;
        cfg_fnum  = '0;
        cfg_block = '0;
        cfg_mult  = '0;
        cfg_key   = 1'b0;
        check_en  = 1'b1;
        errors    = 0;
        err_mark  = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'h77db));

        // pulses arrive while reset is held and keep coming after it
        for (n = 0; n < 16; n++) begin
            @(posedge clk);
            sample_en <= n[0];
        end
        @(posedge clk);
        sample_en <= 1'b0;
        arst_n    <= 1'b1;
        for (n = 0; n < 10; n++) pulse(0);
        finish_test(1, "reset state");

        set_freq(10'h2A5, 3'd4, 1'b0);
        set_mult(4'h1);
        set_freq(10'h2A5, 3'd4, 1'b1);
        for (n = 0; n < 64; n++) pulse(0);
        finish_test(2, "basic stepping");

        for (k = 0; k < 16; k++) begin
            set_mult(4'(k));
            restart_key();
            for (n = 0; n < 20; n++) pulse(0);
        end
        finish_test(3, "multiplier table");

        // block 7 and factors of 12 or 15 wrap within a couple of pulses
        for (k = 0; k < 3; k++) begin
            rnd_fnum = 10'($urandom) | 10'h200;
            set_mult(4'hC + 4'($urandom % 4));
            set_freq(rnd_fnum, 3'd7, 1'b1);
            for (n = 0; n < 200; n++) pulse(0);
        end
        finish_test(4, "block shift and wrap");

        set_freq(10'h1C3, 3'd3, 1'b1);
        set_mult(4'h5);
        restart_key();
        for (n = 0; n < 30; n++) pulse(0);
        set_freq(cfg_fnum, cfg_block, 1'b0); // dropping key-on keeps the phase running
        for (n = 0; n < 5; n++) pulse(0);
        set_freq(cfg_fnum, cfg_block, 1'b1);
        check("phase after restart", 32'(phase), 32'd0);
        for (n = 0; n < 20; n++) pulse(0);
        set_freq(cfg_fnum, cfg_block, 1'b0);
        check_en = 1'b0;
        @(posedge clk);
        wr    <= 1'b1;
        addr  <= `OPL3_ADDR_CTRL;
        wdata <= {2'b00, 1'b1, cfg_block, cfg_fnum[`OPL3_FNUM_W-1:8]};
        @(posedge clk);
        wr        <= 1'b0;
        sample_en <= 1'b1; // key_on rises on this edge, so the pulse meets the edge
        @(posedge clk);
        sample_en <= 1'b0;
        model_acc = '0;
        cfg_key   = 1'b1;
        @(negedge clk);
        check("phase after key-on with pulse", 32'(phase), 32'd0);
        settle();
        check_en = 1'b1;
        for (n = 0; n < 20; n++) pulse(0);
        finish_test(5, "key-on restart");

        set_freq(10'($urandom), 3'($urandom), 1'b1);
        set_mult(4'($urandom));
        restart_key();
        for (n = 0; n < 100; n++) begin
            if (n % 10 == 5) begin
                rnd_addr = 8'($urandom);
                while (is_mapped(rnd_addr)) rnd_addr = rnd_addr + 8'd1;
                write_reg(rnd_addr, 8'($urandom)); // must leave the operator untouched
            end
            pulse($urandom % 6);
        end
        finish_test(6, "ignored writes and gaps");

        $display("tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/opl3_phase_gen.sv
//====================
// opl3 phase generator
// one operator from register writes to phase output
//====================
`timescale 1ns/1ns
`default_nettype none

`include "opl3_consts.svh"

module opl3_phase_gen (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wr,        // host write strobe
    input  logic [`OPL3_ADDR_W-1:0]  addr,
    input  opl3_reg_pkg::reg_wdata_u wdata,
    input  logic                     sample_en, // one pulse per output sample
    output opl3_phase_pkg::phase_t   phase
);
    import opl3_phase_pkg::*;
    import opl3_reg_pkg::*;

    op_cfg_t    op_cfg;    // operator state, one cycle after the write
    phase_inc_t phase_inc; // four cycles after the write

    opl3_op_regs i_opl3_op_regs (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (wr),
        .addr   (addr),
        .wdata  (wdata),
        .op_cfg (op_cfg)
    );

    nco_control i_nco_control (
        .clk       (clk),
        .arst_n    (arst_n),
        .freq      (op_cfg.freq),
        .phase_inc (phase_inc)
    );

    // key_on skips the increment pipeline so a restart is not delayed by it
    nco #(
        .PHASE_ACC_WIDTH (`OPL3_PHASE_ACC_W),
        .OUTPUT_WIDTH    (`OPL3_PHASE_OUT_W)
    ) i_nco (
        .clk       (clk),
        .arst_n    (arst_n),
        .sample_en (sample_en),
        .key_on    (op_cfg.key_on),
        .phase_inc (phase_inc),
        .phase     (phase)
    );

endmodule

`default_nettype wire

//--- design/nco.sv
//====================
// nco phase accumulator
// steps on sample enable and restarts on a key-on edge
//====================
`timescale 1ns/1ns
`default_nettype none

`include "opl3_consts.svh"

module nco #(
    parameter int PHASE_ACC_WIDTH = `OPL3_PHASE_ACC_W,
    parameter int OUTPUT_WIDTH    = `OPL3_PHASE_OUT_W
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       sample_en, // single cycle step request
    input  logic                       key_on,    // level from the register file
    input  opl3_phase_pkg::phase_inc_t phase_inc,
    output logic [OUTPUT_WIDTH-1:0]    phase      // top accumulator bits
);

    logic [PHASE_ACC_WIDTH-1:0] acc_q;    // phase accumulator, wraps modulo 2**width
    logic [PHASE_ACC_WIDTH-1:0] inc_ext;  // increment resized to the accumulator
    logic                       key_on_q; // key_on one cycle ago
    logic                       key_on_rise;

    generate
        if (OUTPUT_WIDTH > PHASE_ACC_WIDTH) begin : g_width_check
            $error("nco output is wider than its accumulator");
        end
    endgenerate

    assign inc_ext     = PHASE_ACC_WIDTH'(phase_inc);
    assign key_on_rise = key_on && !key_on_q; // note starts on this cycle

    // a restart beats a step that arrives in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q    <= '0;
            key_on_q <= 1'b0;
        end else begin
            key_on_q <= key_on;
            if (key_on_rise) begin
                acc_q <= '0;
            end else if (sample_en) begin
                acc_q <= acc_q + inc_ext; // carry out is dropped
            end
        end
    end

    assign phase = acc_q[PHASE_ACC_WIDTH-1 -: OUTPUT_WIDTH];

    // the phase may only move on a step or a restart
    a_acc_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        (!sample_en && !key_on_rise) |=> $stable(acc_q)
    ) else $error("accumulator changed without sample enable or key-on");

endmodule

`default_nettype wire

//--- design/nco_control.sv
//====================
// nco increment pipeline
// F-number, block and multiplier to phase increment in three stages
//====================
`timescale 1ns/1ns
`default_nettype none

`include "opl3_consts.svh"

module nco_control (
    input  logic                       clk,
    input  logic                       arst_n,
    input  opl3_phase_pkg::freq_cfg_t  freq,      // registered operator frequency setting
    output opl3_phase_pkg::phase_inc_t phase_inc  // three cycles behind freq
);
    import opl3_phase_pkg::*;

    phase_inc_t               pre_mult;    // stage 1, F-number shifted by block
    logic [`OPL3_MULT_W-1:0]  mult_s1;     // multiplier code kept in step with stage 1
    logic [`OPL3_MULT_W-1:0]  mult_factor; // integer factor for codes 1 to F
    phase_inc_t               post_mult_d; // stage 2 input, product or half
    phase_inc_t               post_mult;   // stage 2, scaled increment

    // stage 1 shifts the F-number into its octave, block 7 still fits in 17 bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_mult <= '0;
            mult_s1  <= '0;
        end else begin
            pre_mult <= phase_inc_t'(freq.fnum) << freq.block;
            mult_s1  <= freq.mult; // travels with its own F-number so configurations can overlap
        end
    end

    // codes above A repeat factors instead of following the code value
    always_comb begin
        case (mult_s1)
            4'hB:       mult_factor = 4'd10;
            4'hC, 4'hD: mult_factor = 4'd12;
            4'hE, 4'hF: mult_factor = 4'd15;
            default:    mult_factor = mult_s1; // codes 1 to A are their own factor
        endcase
    end

    // code 0 halves the increment, the product is truncated to the accumulator width
    assign post_mult_d = (mult_s1 == '0) ? (pre_mult >> 1)
                                         : pre_mult * phase_inc_t'(mult_factor);

    // stage 2 registers the scaled value, stage 3 is the output register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            post_mult <= '0;
            phase_inc <= '0;
        end else begin
            post_mult <= post_mult_d;
            phase_inc <= post_mult;
        end
    end

    // an unknown multiplier from the register file would poison every later increment
    a_mult_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(freq.mult)
    ) else $error("multiplier code unknown after reset");

endmodule

`default_nettype wire

//--- design/opl3_op_regs.sv
//====================
// opl3 operator registers
// decodes byte writes from the host into the operator configuration
// three addresses are mapped and every other address is ignored
//====================
`timescale 1ns/1ns
`default_nettype none

`include "opl3_consts.svh"

module opl3_op_regs (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       wr,     // single cycle write strobe
    input  logic [`OPL3_ADDR_W-1:0]    addr,
    input  opl3_reg_pkg::reg_wdata_u   wdata,
    output opl3_reg_pkg::op_cfg_t      op_cfg  // registered, valid one cycle after the write
);

    logic wr_fnum_lo; // write hits the low F-number byte
    logic wr_ctrl;    // write hits key-on, block and high F-number
    logic wr_op;      // write hits the multiplier register

    // one strobe per mapped register, unknown addresses give none of them
    assign wr_fnum_lo = wr && (addr == `OPL3_ADDR_FNUM_LO);
    assign wr_ctrl    = wr && (addr == `OPL3_ADDR_CTRL);
    assign wr_op      = wr && (addr == `OPL3_ADDR_OP);

    // the F-number is split over two registers and each write only touches its own part
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_cfg.key_on     <= `OPL3_KEY_ON_RST;
            op_cfg.freq.fnum  <= `OPL3_FNUM_RST;
            op_cfg.freq.block <= `OPL3_BLOCK_RST;
            op_cfg.freq.mult  <= `OPL3_MULT_RST;
        end else begin
            if (wr_fnum_lo) begin
                op_cfg.freq.fnum[`OPL3_DATA_W-1:0] <= wdata.fnum_lo; // whole byte is F-number
            end
            if (wr_ctrl) begin
                op_cfg.key_on     <= wdata.ctrl.key_on;  // nco sees the edge next cycle
                op_cfg.freq.block <= wdata.ctrl.block;
                op_cfg.freq.fnum[`OPL3_FNUM_W-1:`OPL3_DATA_W] <= wdata.ctrl.fnum_hi;
            end
            if (wr_op) begin
                op_cfg.freq.mult <= wdata.op.mult; // am, vib, egt and ksr have no user here
            end
        end
    end

    // a write with an unknown address could land in any register
    a_addr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr |-> !$isunknown(addr)
    ) else $error("register write with unknown address");

endmodule

`default_nettype wire

//--- design/opl3_reg_pkg.sv
//====================
// opl3 register map types
// write data views and the operator configuration word
//====================
`default_nettype none

`include "opl3_consts.svh"

package opl3_reg_pkg;

    // data layout of a write to the control register at B0
    typedef struct packed {
        logic [1:0]                           rsvd;    // unused in this slice
        logic                                 key_on;  // note on when set
        logic [`OPL3_BLOCK_W-1:0]             block;   // octave
        logic [`OPL3_FNUM_W-`OPL3_DATA_W-1:0] fnum_hi; // top two F-number bits
    } reg_ctrl_t;

    // data layout of a write to the operator register at 20
    typedef struct packed {
        logic                    am;   // tremolo enable, no tremolo here
        logic                    vib;  // vibrato enable, no vibrato here
        logic                    egt;  // sustain mode of the envelope
        logic                    ksr;  // key scale rate of the envelope
        logic [`OPL3_MULT_W-1:0] mult; // frequency multiplier code
    } reg_op_t;

    // one data byte with the meaning picked by the register address
    typedef union packed {
        logic [`OPL3_DATA_W-1:0] fnum_lo; // view used for address A0
        reg_ctrl_t               ctrl;    // view used for address B0
        reg_op_t                 op;      // view used for address 20
    } reg_wdata_u;

    // complete operator state held by the register file
    typedef struct packed {
        logic                     key_on; // level, edges restart the phase
        opl3_phase_pkg::freq_cfg_t freq;  // feeds the increment pipeline
    } op_cfg_t;

endpackage

`default_nettype wire

//--- design/opl3_phase_pkg.sv
//====================
// opl3 phase types
// frequency setting, increment and phase words of the NCO path
//====================
`default_nettype none

`include "opl3_consts.svh"

package opl3_phase_pkg;

    // increment added to the accumulator on every sample enable
    typedef logic [`OPL3_PHASE_ACC_W-1:0] phase_inc_t;

    // operator phase as seen by a waveform lookup
    typedef logic [`OPL3_PHASE_OUT_W-1:0] phase_t;

    // everything that sets the operator frequency
    typedef struct packed {
        logic [`OPL3_FNUM_W-1:0]  fnum;   // frequency number
        logic [`OPL3_BLOCK_W-1:0] block;  // octave, left shift of fnum
        logic [`OPL3_MULT_W-1:0]  mult;   // multiplier code 0 to F
    } freq_cfg_t;

endpackage

`default_nettype wire

//--- design/opl3_consts.svh
//====================
// opl3 operator constants
// field widths, register map and reset values of the phase slice
//====================
`ifndef OPL3_CONSTS_SVH
`define OPL3_CONSTS_SVH

// operator frequency fields
`define OPL3_FNUM_W        10       // frequency number, split over two registers
`define OPL3_BLOCK_W       3        // octave shift applied to the F-number
`define OPL3_MULT_W        4        // multiplier code, decoded to a factor table

// phase path
`define OPL3_PHASE_ACC_W   20       // accumulator and increment width
`define OPL3_PHASE_OUT_W   10       // top accumulator bits presented as phase

// host register port
`define OPL3_ADDR_W        8
`define OPL3_DATA_W        8
`define OPL3_ADDR_OP       8'h20    // am, vib, egt, ksr and mult
`define OPL3_ADDR_FNUM_LO  8'hA0    // low F-number byte
`define OPL3_ADDR_CTRL     8'hB0    // key-on, block and high F-number bits

// register contents after reset
`define OPL3_KEY_ON_RST    1'b0
`define OPL3_FNUM_RST      10'h000
`define OPL3_BLOCK_RST     3'h0
`define OPL3_MULT_RST      4'h0

`endif
